// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hw/rv_isa_pkg.sv
  - hw/rv_ctrl_pkg.sv
  - hw/ctrl.sv
  - hw/core_fsm.sv
  - hw/pc_unit.sv
  - hw/regfile.sv
  - hw/exec_unit.sv
  - hw/rv_core.sv
  - target: simulation
    files:
      - sim/rv_core_asserts.sv
      - sim/rv_core_tb.sv

// ==== hw/core_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_fsm import rv_ctrl_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  ctrl_t dec,
    output logic  fetch_en,
    output logic  decode_en,
    output logic  exec_en,
    output logic  mem_en,
    output logic  wb_en,
    output logic  halted,
    output logic  illegal
);

    core_state_e state;
    core_state_e state_nxt;
    logic        illegal_q;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_FETCH:  state_nxt = ST_DECODE;
            ST_DECODE: state_nxt = (dec.ebreak || dec.illegal) ? ST_HALT : ST_EXEC;
            ST_EXEC:   state_nxt = (dec.mem_read || dec.mem_write) ? ST_MEM : ST_WB;
            ST_MEM:    state_nxt = ST_WB;
            ST_WB:     state_nxt = ST_FETCH;
            ST_HALT:   state_nxt = ST_HALT;   // only reset leaves
            default:   state_nxt = ST_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_FETCH;
            illegal_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ST_DECODE && dec.illegal) begin
                illegal_q <= 1'b1;            // sticky
            end
        end
    end

    assign fetch_en  = (state == ST_FETCH);
    assign decode_en = (state == ST_DECODE);
    assign exec_en   = (state == ST_EXEC);
    assign mem_en    = (state == ST_MEM);
    assign wb_en     = (state == ST_WB);
    assign halted    = (state == ST_HALT);
    assign illegal   = illegal_q;

endmodule

`default_nettype wire

// ==== hw/ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  inst_t inst,
    output ctrl_t dec
);

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      known;
    logic      is_ebreak;

    assign opcode    = inst[6:0];
    assign funct3    = inst[FUNCT3_BASE +: $bits(funct3_t)];
    assign funct7    = inst[FUNCT7_BASE +: $bits(funct7_t)];
    assign rd        = inst[RD_BASE +: REG_AW];
    assign rs1       = inst[RS1_BASE +: REG_AW];
    assign rs2       = inst[RS2_BASE +: REG_AW];
    assign is_ebreak = (inst == EBREAK_INST);

    always_comb begin
        dec         = '0;             // no write, no jump, no memory access
        dec.imm_sel = IMM_I;
        dec.alu_op  = ALU_ADD;
        dec.alu_src = ALU_SRC_REG;
        dec.res_ext = EXT_NONE;
        known       = 1'b1;
        case (opcode)
            OP: begin
                known       = (funct3 == F3_ADD_SUB) && (funct7 == F7_ADD || funct7 == F7_SUB);
                dec.reg_wen = known;
                dec.rs1     = rs1;
                dec.rs2     = rs2;
                dec.rd      = rd;
                dec.alu_op  = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
            end
            OP_IMM: begin
                known       = (funct3 == F3_ADD_SUB) || (funct3 == F3_SLTIU);
                dec.reg_wen = known;
                dec.rs1     = rs1;
                dec.rd      = rd;
                dec.alu_src = ALU_SRC_IMM;
                dec.alu_op  = (funct3 == F3_SLTIU) ? ALU_SLTU : ALU_ADD;
            end
            OP_32: begin                  // addw only
                known       = (funct3 == F3_ADD_SUB) && (funct7 == F7_ADD);
                dec.reg_wen = known;
                dec.rs1     = rs1;
                dec.rs2     = rs2;
                dec.rd      = rd;
                dec.res_ext = EXT_WORD;
            end
            LOAD: begin
                known        = (funct3 == F3_LW);
                dec.reg_wen  = known;
                dec.mem_read = known;
                dec.rs1      = rs1;
                dec.rd       = rd;
                dec.alu_src  = ALU_SRC_IMM;
                dec.res_ext  = EXT_LOAD_W;
            end
            STORE: begin
                // base in rs1, data in rs2, nothing written back
                known         = (funct3 == F3_SD);
                dec.mem_write = known;
                dec.rs1       = rs1;
                dec.rs2       = rs2;
                dec.imm_sel   = IMM_S;
                dec.alu_src   = ALU_SRC_IMM;
            end
            JAL: begin
                dec.jump    = 1'b1;
                dec.reg_wen = 1'b1;
                dec.rd      = rd;
                dec.imm_sel = IMM_J;
                dec.alu_src = ALU_SRC_FOUR_PC;
            end
            JALR: begin
                known       = (funct3 == F3_JALR);
                dec.jump    = known;
                dec.jalr    = known;
                dec.reg_wen = known;
                dec.rs1     = rs1;
                dec.rd      = rd;
                dec.alu_src = ALU_SRC_FOUR_PC;
            end
            LUI: begin
                dec.reg_wen = 1'b1;       // x0 + imm
                dec.rd      = rd;
                dec.imm_sel = IMM_U;
                dec.alu_src = ALU_SRC_IMM;
            end
            AUIPC: begin
                dec.reg_wen = 1'b1;
                dec.rd      = rd;
                dec.imm_sel = IMM_U;
                dec.alu_src = ALU_SRC_IMM_PC;
            end
            BRANCH: begin
                known         = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                dec.branch    = known;
                dec.branch_eq = (funct3 == F3_BEQ);
                dec.rs1       = rs1;
                dec.rs2       = rs2;
                dec.imm_sel   = IMM_B;
                dec.alu_op    = ALU_SUB;  // taken on zero / not zero
            end
            default: known = 1'b0;
        endcase
        dec.ebreak  = is_ebreak;
        dec.illegal = !known && !is_ebreak;
    end

endmodule

`default_nettype wire

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  ctrl_t dec,
    input  inst_t inst,
    input  addr_t pc,
    input  xlen_t rs1_val,
    input  xlen_t rs2_val,
    input  xlen_t load_data,
    output xlen_t imm,
    output xlen_t result,
    output addr_t mem_addr,
    output xlen_t store_data,
    output logic  zero
);

    xlen_t       op_a;
    xlen_t       op_b;
    xlen_t       alu_res;
    logic [31:0] load_word;

    always_comb begin
        case (dec.imm_sel)
            IMM_S:   imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B:   imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U:   imm = {{32{inst[31]}}, inst[31:12], 12'b0};
            IMM_J:   imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = {{52{inst[31]}}, inst[31:20]};
        endcase
    end

    always_comb begin
        op_a = rs1_val;
        op_b = rs2_val;
        case (dec.alu_src)
            ALU_SRC_IMM: op_b = imm;
            ALU_SRC_IMM_PC: begin
                op_a = pc;
                op_b = imm;
            end
            ALU_SRC_FOUR_PC: begin
                op_a = pc;
                op_b = xlen_t'(4);
            end
            default: ;
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLTU: alu_res = xlen_t'(op_a < op_b);
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    assign zero       = (alu_res == '0);
    assign mem_addr   = rs1_val + imm;
    assign store_data = rs2_val;
    assign load_word  = mem_addr[2] ? load_data[63:32] : load_data[31:0];  // word in doubleword

    always_comb begin
        case (dec.res_ext)
            EXT_WORD:   result = {{32{alu_res[31]}}, alu_res[31:0]};
            EXT_LOAD_W: result = {{32{load_word[31]}}, load_word};
            default:    result = alu_res;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  upd,
    input  ctrl_t dec,
    input  xlen_t rs1_val,
    input  xlen_t imm,
    input  logic  zero,
    output addr_t pc
);

    logic  taken;
    addr_t pc_nxt;

    assign taken = dec.branch && (dec.branch_eq ? zero : !zero);

    always_comb begin
        if (dec.jalr) begin
            pc_nxt = (rs1_val + imm) & ~addr_t'(1);   // clear bit 0
        end else if (dec.jump || taken) begin
            pc_nxt = pc + imm;                        // J or B immediate
        end else begin
            pc_nxt = pc + addr_t'(4);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (upd) begin
            pc <= pc_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import rv_isa_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output xlen_t     rs1_val,
    output xlen_t     rs2_val,
    input  logic      we,
    input  reg_addr_t rd,
    input  xlen_t     wdata
);

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];   // x0 hardwired
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    output addr_t  imem_addr,
    input  inst_t  imem_rdata,
    output addr_t  dmem_addr,
    output xlen_t  dmem_wdata,
    output wmask_t dmem_wmask,
    output logic   dmem_we,
    input  xlen_t  dmem_rdata,
    output logic   halted,
    output logic   illegal
);

    logic  fetch_en;
    logic  decode_en;
    logic  exec_en;
    logic  mem_en;
    logic  wb_en;
    inst_t inst_q;
    ctrl_t dec;
    ctrl_t dec_q;
    xlen_t rs1_rd;
    xlen_t rs2_rd;
    xlen_t rs1_q;
    xlen_t rs2_q;
    xlen_t imm;
    xlen_t result;
    xlen_t res_q;
    xlen_t store_data;
    addr_t mem_addr;
    addr_t pc;
    logic  zero;

    core_fsm fsm0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec       (dec),
        .fetch_en  (fetch_en),
        .decode_en (decode_en),
        .exec_en   (exec_en),
        .mem_en    (mem_en),
        .wb_en     (wb_en),
        .halted    (halted),
        .illegal   (illegal)
    );

    pc_unit pc0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .upd     (wb_en),
        .dec     (dec_q),
        .rs1_val (rs1_q),
        .imm     (imm),
        .zero    (zero),
        .pc      (pc)
    );

    ctrl ctrl0 (
        .inst (inst_q),
        .dec  (dec)
    );

    regfile rf0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rs1_val (rs1_rd),
        .rs2_val (rs2_rd),
        .we      (wb_en && dec_q.reg_wen),
        .rd      (dec_q.rd),
        .wdata   (res_q)
    );

    exec_unit ex0 (
        .dec        (dec_q),
        .inst       (inst_q),
        .pc         (pc),
        .rs1_val    (rs1_q),
        .rs2_val    (rs2_q),
        .load_data  (dmem_rdata),
        .imm        (imm),
        .result     (result),
        .mem_addr   (mem_addr),
        .store_data (store_data),
        .zero       (zero)
    );

    always_ff @(posedge clk) begin
        if (fetch_en) begin
            inst_q <= imem_rdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_q <= '0;
        end else if (decode_en) begin
            dec_q <= dec;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en) begin
            rs1_q <= rs1_rd;
            rs2_q <= rs2_rd;
        end
        if (exec_en || (mem_en && dec_q.mem_read)) begin
            res_q <= result;              // lw overwrites in ST_MEM
        end
    end

    assign imem_addr  = pc;
    assign dmem_addr  = mem_addr;
    assign dmem_wdata = store_data;
    assign dmem_we    = mem_en && dec_q.mem_write;   // one cycle per sd
    assign dmem_wmask = {$bits(wmask_t){dec_q.mem_write}};

endmodule

`default_nettype wire

// ==== hw/rv_ctrl_pkg.sv ====
`default_nettype none

package rv_ctrl_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLTU,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_SRC_REG,      // rs1 op rs2
        ALU_SRC_IMM,      // rs1 op imm
        ALU_SRC_IMM_PC,   // pc + imm
        ALU_SRC_FOUR_PC   // pc + 4, link value
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef enum logic [1:0] {
        EXT_NONE,
        EXT_WORD,         // addw
        EXT_LOAD_W        // lw
    } res_ext_e;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_MEM,
        ST_WB,
        ST_HALT
    } core_state_e;

    typedef struct packed {
        logic      branch;
        logic      branch_eq;   // beq when set, bne otherwise
        logic      jump;
        logic      jalr;
        logic      reg_wen;
        logic      mem_read;
        logic      mem_write;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        imm_sel_e  imm_sel;
        alu_op_e   alu_op;
        alu_src_e  alu_src;
        res_ext_e  res_ext;
        logic      ebreak;
        logic      illegal;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== hw/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN     = 64;
    localparam int ILEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [ILEN-1:0]   inst_t;
    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [6:0]        opcode_t;
    typedef logic [2:0]        funct3_t;
    typedef logic [6:0]        funct7_t;
    typedef logic [XLEN/8-1:0] wmask_t;    // one bit per byte lane

    localparam int RD_BASE     = 7;
    localparam int FUNCT3_BASE = 12;
    localparam int RS1_BASE    = 15;
    localparam int RS2_BASE    = 20;
    localparam int FUNCT7_BASE = 25;

    localparam opcode_t OP     = 7'b0110011;
    localparam opcode_t OP_IMM = 7'b0010011;
    localparam opcode_t OP_32  = 7'b0111011;
    localparam opcode_t LOAD   = 7'b0000011;
    localparam opcode_t STORE  = 7'b0100011;
    localparam opcode_t JAL    = 7'b1101111;
    localparam opcode_t JALR   = 7'b1100111;
    localparam opcode_t LUI    = 7'b0110111;
    localparam opcode_t AUIPC  = 7'b0010111;
    localparam opcode_t BRANCH = 7'b1100011;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLTIU   = 3'b011;
    localparam funct3_t F3_LW      = 3'b010;
    localparam funct3_t F3_SD      = 3'b011;
    localparam funct3_t F3_JALR    = 3'b000;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;

    localparam funct7_t F7_ADD = 7'b0000000;
    localparam funct7_t F7_SUB = 7'b0100000;

    localparam inst_t EBREAK_INST = 32'h0010_0073;
    localparam addr_t RESET_PC    = '0;

endpackage

`default_nettype wire

// ==== rv_core.f ====
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/ctrl.sv
hw/core_fsm.sv
hw/pc_unit.sv
hw/regfile.sv
hw/exec_unit.sv
hw/rv_core.sv
sim/rv_core_asserts.sv
sim/rv_core_tb.sv

// ==== sim/rv_core_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts import rv_isa_pkg::*; (
    input logic   clk,
    input logic   arst_n,
    input addr_t  imem_addr,
    input wmask_t dmem_wmask,
    input logic   dmem_we,
    input logic   halted
);

    int unsigned fail_count = 0;   // watched by the testbench

    we_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_we |=> !dmem_we)
        else begin
            $error("dmem_we high in two consecutive cycles");
            fail_count++;
        end

    wmask_full: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_we |-> (dmem_wmask == '1))
        else begin
            $error("dmem_wmask not all ones on a store");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        !$fell(halted))
        else begin
            $error("halted fell outside reset");
            fail_count++;
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        imem_addr[1:0] == 2'b00)
        else begin
            $error("imem_addr not word aligned");
            fail_count++;
        end

endmodule

bind rv_core rv_core_asserts asserts0 (.*);

`default_nettype wire

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_isa_pkg::*; ();

    localparam int          RESET_CYCLES   = 10;
    localparam int          TIMEOUT_CYCLES = 5 * 256 + RESET_CYCLES;
    localparam logic [31:0] SEED           = 32'h92049ca2;
    localparam logic [6:0]  OPC_OP         = 7'h33;
    localparam logic [6:0]  OPC_IMM        = 7'h13;
    localparam logic [6:0]  OPC_OP32       = 7'h3b;
    localparam logic [6:0]  OPC_LOAD       = 7'h03;
    localparam logic [6:0]  OPC_STORE      = 7'h23;
    localparam logic [6:0]  OPC_JAL        = 7'h6f;
    localparam logic [6:0]  OPC_JALR       = 7'h67;
    localparam logic [6:0]  OPC_LUI        = 7'h37;
    localparam logic [6:0]  OPC_AUIPC      = 7'h17;
    localparam logic [6:0]  OPC_BRANCH     = 7'h63;
    localparam inst_t       EBREAK         = 32'h0010_0073;

    logic   clk = 1'b0;
    logic   arst_n = 1'b0;
    addr_t  imem_addr;
    inst_t  imem_rdata;
    addr_t  dmem_addr;
    xlen_t  dmem_wdata;
    wmask_t dmem_wmask;
    logic   dmem_we;
    xlen_t  dmem_rdata;
    logic   halted;
    logic   illegal;
    inst_t  imem [256];
    xlen_t  dmem [64];
    inst_t  prog [$];
    int     cycles = 0;
    int     stores;
    string  test_name = "none";

    rv_core dut0 (.*);

    always #20 clk = ~clk;

    assign imem_rdata = imem[8'(imem_addr >> 2)];
    assign dmem_rdata = dmem[6'(dmem_addr >> 3)];

    function automatic xlen_t merge_bytes(input xlen_t old_val, input xlen_t new_val,
                                          input wmask_t mask);
        xlen_t merged;
        merged = old_val;
        for (int b = 0; b < $bits(wmask_t); b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return merged;
    endfunction

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[6'(dmem_addr >> 3)] = merge_bytes(dmem[6'(dmem_addr >> 3)], dmem_wdata,
                                                   dmem_wmask);   // only enabled lanes
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stores <= 0;
        end else if (dmem_we) begin
            stores <= stores + 1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("core never halted in test %s within %0d cycles", test_name, TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk) begin
        if (dut0.asserts0.fail_count != 0) begin
            $display("an assertion on the DUT ports failed in test %s", test_name);
            $display("CHECKS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    function automatic xlen_t sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic xlen_t sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic xlen_t fill_word(input int idx);
        return {16'hf111, idx[15:0], 16'h0e0e, ~idx[15:0]};
    endfunction

    function automatic inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t addi(input logic [4:0] rd, input logic [4:0] rs1,
                                   input logic [11:0] imm);
        return i_type(imm, rs1, 3'b000, rd, OPC_IMM);
    endfunction

    function automatic inst_t lw(input logic [4:0] rd, input logic [4:0] rs1,
                                 input logic [11:0] imm);
        return i_type(imm, rs1, 3'b010, rd, OPC_LOAD);
    endfunction

    function automatic inst_t sd(input logic [4:0] rs2, input logic [4:0] rs1,
                                 input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic inst_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic inst_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic prepare_memories(input string name);
        test_name = name;
        arst_n    = 1'b0;
        prog.delete();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[24:0], 7'h7f};   // unknown opcode, halts as illegal
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(i);
        end
    endtask

    task automatic execute_program();
        foreach (prog[i]) begin
            imem[i] = prog[i];
        end
        cycles = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
    endtask

    task automatic arithmetic_ops();
        logic [11:0] a;
        logic [11:0] b;
        logic [19:0] u;
        xlen_t       vu;
        a  = 12'($urandom);
        b  = 12'($urandom);
        u  = 20'($urandom) | 20'h40000;   // doubled value has bit 31 set
        vu = sext32({u, 12'h000});
        prepare_memories("arith");
        prog.push_back(addi(5'd1, 5'd0, a));
        prog.push_back(addi(5'd2, 5'd0, b));
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP));
        prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4, OPC_OP));
        prog.push_back(i_type(b, 5'd1, 3'b011, 5'd5, OPC_IMM));
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd6, OPC_OP32));
        prog.push_back(u_type(u, 5'd7, OPC_LUI));
        prog.push_back(r_type(7'h00, 5'd7, 5'd7, 3'b000, 5'd8, OPC_OP32));
        for (int r = 3; r <= 8; r++) begin
            prog.push_back(sd(5'(r), 5'd0, 12'((r - 3) * 8)));
        end
        prog.push_back(EBREAK);
        execute_program();
        check_value("arith add", sext12(a) + sext12(b), dmem[0]);
        check_value("arith sub", sext12(a) - sext12(b), dmem[1]);
        check_value("arith sltiu", xlen_t'(sext12(a) < sext12(b)), dmem[2]);
        check_value("arith addw", sext32(32'(sext12(a) + sext12(b))), dmem[3]);
        check_value("arith lui", vu, dmem[4]);
        check_value("arith addw overflow", sext32(32'(vu + vu)), dmem[5]);
    endtask

    task automatic load_store();
        logic [31:0] lo;
        logic [31:0] hi;
        lo = $urandom & 32'h7fff_ffff;
        hi = $urandom | 32'h8000_0000;   // negative word
        prepare_memories("load_store");
        dmem[8] = {hi, lo};
        prog.push_back(addi(5'd3, 5'd0, 12'd64));
        prog.push_back(lw(5'd1, 5'd3, 12'd0));
        prog.push_back(lw(5'd2, 5'd3, 12'd4));
        prog.push_back(sd(5'd1, 5'd0, 12'd128));
        prog.push_back(sd(5'd2, 5'd0, 12'd136));
        prog.push_back(EBREAK);
        execute_program();
        check_value("lw positive", sext32(lo), dmem[16]);
        check_value("lw negative", sext32(hi), dmem[17]);
        check_value("lw source kept", {hi, lo}, dmem[8]);
    endtask

    // taken path skips the first marker, not-taken path jumps over the second
    task automatic add_branch_block(input logic [2:0] f3, input logic [4:0] rs2, input int idx);
        prog.push_back(b_type(13'd12, rs2, 5'd1, f3));
        prog.push_back(addi(5'd11, 5'd0, 12'(12'h100 + idx)));
        prog.push_back(j_type(21'd8, 5'd0));
        prog.push_back(addi(5'd11, 5'd0, 12'(12'h200 + idx)));
        prog.push_back(sd(5'd11, 5'd0, 12'(8 * idx)));
    endtask

    task automatic branch_paths();
        logic [11:0] v;
        logic [11:0] w;
        logic        eq;
        logic        taken;
        v = 12'($urandom);
        w = v ^ 12'(1 + $urandom % 4095);
        prepare_memories("branch");
        prog.push_back(addi(5'd1, 5'd0, v));
        prog.push_back(addi(5'd2, 5'd0, v));
        prog.push_back(addi(5'd3, 5'd0, w));
        add_branch_block(3'b000, 5'd2, 0);
        add_branch_block(3'b000, 5'd3, 1);
        add_branch_block(3'b001, 5'd2, 2);
        add_branch_block(3'b001, 5'd3, 3);
        prog.push_back(EBREAK);
        execute_program();
        for (int i = 0; i < 4; i++) begin
            eq    = (i % 2 == 0) ? 1'b1 : (sext12(v) == sext12(w));
            taken = (i < 2) ? eq : !eq;
            check_value("branch marker", xlen_t'(taken ? 12'h200 + i : 12'h100 + i), dmem[i]);
        end
    endtask

    task automatic jump_upper();
        logic [19:0] u1;
        logic [19:0] u2;
        u1 = 20'($urandom);
        u2 = 20'($urandom);
        prepare_memories("jump");
        prog.push_back(u_type(u1, 5'd1, OPC_LUI));
        prog.push_back(u_type(u2, 5'd2, OPC_AUIPC));
        prog.push_back(j_type(21'd8, 5'd3));            // to 16
        prog.push_back(addi(5'd9, 5'd0, 12'd1));
        prog.push_back(addi(5'd5, 5'd0, 12'd32));
        prog.push_back(i_type(12'd1, 5'd5, 3'b000, 5'd4, OPC_JALR));   // 33 -> 32
        prog.push_back(addi(5'd9, 5'd0, 12'd2));
        prog.push_back(addi(5'd9, 5'd0, 12'd3));
        for (int r = 1; r <= 4; r++) begin
            prog.push_back(sd(5'(r), 5'd0, 12'((r - 1) * 8)));
        end
        prog.push_back(sd(5'd9, 5'd0, 12'd32));
        prog.push_back(EBREAK);
        execute_program();
        check_value("lui", sext32({u1, 12'h000}), dmem[0]);
        check_value("auipc", xlen_t'(4) + sext32({u2, 12'h000}), dmem[1]);
        check_value("jal link", xlen_t'(2 * 4 + 4), dmem[2]);
        check_value("jalr link", xlen_t'(5 * 4 + 4), dmem[3]);
        check_value("skipped code", xlen_t'(0), dmem[4]);
    endtask

    task automatic halt_illegal();
        prepare_memories("ebreak");
        prog.push_back(addi(5'd1, 5'd0, 12'h055));
        prog.push_back(sd(5'd1, 5'd0, 12'd0));
        prog.push_back(EBREAK);
        prog.push_back(sd(5'd1, 5'd0, 12'd8));
        execute_program();
        repeat (20) @(negedge clk);
        check_value("ebreak halted", xlen_t'(1), xlen_t'(halted));
        check_value("ebreak illegal", xlen_t'(0), xlen_t'(illegal));
        check_value("ebreak stores", xlen_t'(1), xlen_t'(stores));
        check_value("ebreak store before", xlen_t'(12'h055), dmem[0]);
        check_value("ebreak store after", fill_word(1), dmem[1]);
        prepare_memories("illegal");
        prog.push_back(addi(5'd1, 5'd0, 12'h066));
        prog.push_back(sd(5'd1, 5'd0, 12'd0));
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd3, OPC_OP));   // or
        prog.push_back(sd(5'd1, 5'd0, 12'd8));
        prog.push_back(EBREAK);
        execute_program();
        repeat (20) @(negedge clk);
        check_value("illegal halted", xlen_t'(1), xlen_t'(halted));
        check_value("illegal flag", xlen_t'(1), xlen_t'(illegal));
        check_value("illegal stores", xlen_t'(1), xlen_t'(stores));
        check_value("illegal store after", fill_word(1), dmem[1]);
    endtask

    initial begin
        void'($urandom(SEED));
        arithmetic_ops();
        load_store();
        branch_paths();
        jump_upper();
        halt_illegal();
        if (dut0.asserts0.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire
